// File: compile.f
icache_pkg.sv
fill_if.sv
icache_tag_store.sv
icache_data_store.sv
icache_ctrl.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

// File: Bender.yml
package:
  name: icache

sources:
  - icache_pkg.sv
  - fill_if.sv
  - icache_tag_store.sv
  - icache_data_store.sv
  - icache_ctrl.sv
  - icache_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_icache.sv

// File: tb_icache.sv
`default_nettype none

module tb_icache
    import icache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int idx_w = 4;
    localparam int off_w = woff_w + boff_w;
    localparam int tag_w = addr_w - idx_w - off_w;
    localparam int n_fetches = 400;
    // slowest miss plus gap and hold cycles
    localparam int max_cycles = n_fetches * 14;
    localparam int drive_delay = 2;
    localparam int seed_value = 99278;
    localparam logic [31:0] data_key = 32'h5A3C_96E1;
    localparam logic [31:0] uncached_top = 32'hF000_0000;
    localparam logic [addr_w-1:0] line_bytes = line_words * 4;

    logic              sys_clk;
    logic              arst_n;
    logic              fetch_read;
    logic [addr_w-1:0] fetch_addr;
    logic              fetch_hold;
    logic              flush;
    wire  [word_w-1:0] fetch_data;
    wire               fetch_hit;
    wire               fetch_stall;
    wire               mem_req;
    wire  [addr_w-1:0] mem_addr;
    wire               mem_mmio;
    wire               mem_ack;
    wire  [line_w-1:0] mem_rdata;

    int                seed;
    int                error_count;
    int                check_count;
    int                fetch_count;
    int                flush_count;
    int                req_count;
    int                cycle_count;
    logic              req_prev;
    logic [addr_w-1:0] last_req_addr;
    logic              last_req_mmio;

    // reference copy of the valid and tag table
    logic              model_valid [1 << idx_w];
    logic [tag_w-1:0]  model_tag [1 << idx_w];
    logic [word_w-1:0] exp_mmio;

    icache_top #(.idx_w(idx_w)) i_dut (
        .sys_clk     (sys_clk),
        .arst_n      (arst_n),
        .fetch_read  (fetch_read),
        .fetch_addr  (fetch_addr),
        .fetch_hold  (fetch_hold),
        .flush       (flush),
        .fetch_data  (fetch_data),
        .fetch_hit   (fetch_hit),
        .fetch_stall (fetch_stall),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_mmio    (mem_mmio),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata)
    );

    tb_mem_model #(.seed_init(seed_value), .data_key(data_key)) i_mem (
        .sys_clk   (sys_clk),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_mmio  (mem_mmio),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    // count memory requests by their rising edge
    always @(negedge sys_clk) begin
        if (mem_req && !req_prev) begin
            req_count++;
            last_req_addr = mem_addr;
            last_req_mmio = mem_mmio;
        end
        req_prev = mem_req;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s at %0t expected %h actual %h", name, $time, expected, actual);
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    function automatic logic [addr_w-1:0] pick_address();
        logic [addr_w-1:0] tag_part;
        logic [addr_w-1:0] idx_part;
        logic [addr_w-1:0] word_part;
        logic [addr_w-1:0] addr;
        word_part = rand_below(line_words) << boff_w;
        // three tags share each of two indexes so lines evict each other
        case (rand_below(3))
            0: tag_part = 32'h0000_0000;
            1: tag_part = 32'h0000_1000;
            default: tag_part = 32'h0042_6000;
        endcase
        idx_part = (rand_below(2) == 0 ? 3 : 9) << off_w;
        if (rand_below(5) == 0) begin
            addr = uncached_top | (rand_below(64) << boff_w);
        end else begin
            addr = tag_part | idx_part | word_part;
        end
        return addr;
    endfunction

    function automatic logic model_hit(input logic [addr_w-1:0] addr);
        logic [idx_w-1:0] idx;
        idx = addr[off_w +: idx_w];
        return model_valid[idx] && (model_tag[idx] == addr[addr_w-1 -: tag_w]);
    endfunction

    task automatic clear_model();
        for (int i = 0; i < (1 << idx_w); i++) begin
            model_valid[i] = 1'b0;
            model_tag[i] = '0;
        end
    endtask

    // one cycle without a fetch, optionally with flush
    task automatic run_gap(input logic with_flush);
        fetch_read = 1'b0;
        fetch_hold = 1'b0;
        flush = with_flush;
        @(negedge sys_clk);
        check_value("stall without read", 0, fetch_stall);
        @(posedge sys_clk);
        if (with_flush) begin
            clear_model();
            flush_count++;
        end
        #(drive_delay);
        flush = 1'b0;
    endtask

    // present one address until the word is taken, then check the requests
    task automatic run_fetch(input logic [addr_w-1:0] addr);
        logic              uncached;
        logic              exp_hit;
        logic [word_w-1:0] exp_word;
        logic              first_cycle;
        logic              accepted;
        int                reqs_before;
        uncached = (addr & uncached_top) == uncached_top;
        exp_hit = !uncached && model_hit(addr);
        exp_word = uncached ? exp_mmio : ((addr >> boff_w) ^ data_key);
        reqs_before = req_count;
        first_cycle = 1'b1;
        accepted = 1'b0;
        fetch_read = 1'b1;
        fetch_addr = addr;
        fetch_hold = (rand_below(4) == 0);
        while (!accepted) begin
            @(negedge sys_clk);
            if (first_cycle) begin
                check_value("first cycle hit", exp_hit, fetch_hit);
                check_value("first cycle stall", !exp_hit, fetch_stall);
                first_cycle = 1'b0;
            end
            if (!fetch_stall) begin
                check_value(uncached ? "mmio data" : "cached data", exp_word, fetch_data);
                check_value("hit flag on answer", !uncached, fetch_hit);
                accepted = !fetch_hold;
            end
            @(posedge sys_clk);
            #(drive_delay);
            if (!accepted) begin
                fetch_hold = (rand_below(4) == 0);
            end
        end
        if (uncached) begin
            check_value("mmio request count", 1, req_count - reqs_before);
            check_value("mmio request address", addr, last_req_addr);
            check_value("mmio request flag", 1, last_req_mmio);
            exp_mmio = exp_mmio + 1;
        end else if (exp_hit) begin
            check_value("hit request count", 0, req_count - reqs_before);
        end else begin
            check_value("miss request count", 1, req_count - reqs_before);
            check_value("miss request address", addr & ~(line_bytes - 1), last_req_addr);
            check_value("miss request flag", 0, last_req_mmio);
            model_valid[addr[off_w +: idx_w]] = 1'b1;
            model_tag[addr[off_w +: idx_w]] = addr[addr_w-1 -: tag_w];
        end
        fetch_count++;
    endtask

    initial begin
        int gap_kind;
        seed = seed_value;
        error_count = 0;
        check_count = 0;
        fetch_count = 0;
        flush_count = 0;
        req_count = 0;
        req_prev = 1'b0;
        last_req_addr = '0;
        last_req_mmio = 1'b0;
        exp_mmio = 32'h100;
        clear_model();
        arst_n = 1'b0;
        fetch_read = 1'b0;
        fetch_addr = '0;
        fetch_hold = 1'b0;
        flush = 1'b0;
        @(posedge sys_clk);
        @(negedge sys_clk);
        check_value("mem_req in reset", 0, mem_req);
        @(posedge sys_clk);
        #(drive_delay);
        arst_n = 1'b1;
        for (int n = 0; n < n_fetches; n++) begin
            gap_kind = rand_below(16);
            if (gap_kind == 0) begin
                run_gap(1'b1);
            end else if (gap_kind < 4) begin
                run_gap(1'b0);
            end
            run_fetch(pick_address());
        end
        fetch_read = 1'b0;
        @(posedge sys_clk);
        $display("fetches %0d, flushes %0d, requests %0d, checks %0d, errors %0d",
                 fetch_count, flush_count, req_count, check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        ctrl_state_t stuck_state;
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge sys_clk);
            cycle_count++;
        end
        stuck_state = i_dut.i_ctrl.state;
        $display("timeout after %0d cycles, %0d of %0d fetches done, controller in state %s",
                 cycle_count, fetch_count, n_fetches, stuck_state.name());
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`default_nettype none

module tb_mem_model
    import icache_pkg::*;
#(
    parameter int          seed_init = 1,
    parameter logic [31:0] data_key  = 32'h0
) (
    input  wire               sys_clk,
    input  wire               mem_req,
    input  wire  [addr_w-1:0] mem_addr,
    input  wire               mem_mmio,
    output logic              mem_ack,
    output logic [line_w-1:0] mem_rdata
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int drive_delay = 2;

    int                seed;
    int unsigned       wait_cycles;
    logic [word_w-1:0] mmio_counter;

    // word at byte address a holds (a / 4) ^ data_key
    function automatic logic [line_w-1:0] line_data(input logic [addr_w-1:0] base);
        logic [line_w-1:0] line;
        logic [addr_w-1:0] word_addr;
        line = '0;
        for (int i = 0; i < line_words; i++) begin
            word_addr = (base >> 2) + i;
            line[i*word_w +: word_w] = word_addr ^ data_key;
        end
        return line;
    endfunction

    initial begin
        seed = seed_init;
        mmio_counter = 32'h100;
        mem_ack = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge sys_clk);
            #(drive_delay);
            if (mem_req && !mem_ack) begin
                // answer 1 to 4 cycles after the request is seen
                wait_cycles = 1 + ($unsigned($random(seed)) % 4);
                repeat (wait_cycles) @(posedge sys_clk);
                #(drive_delay);
                if (mem_mmio) begin
                    mem_rdata = {{(line_w - word_w){1'b0}}, mmio_counter};
                    mmio_counter = mmio_counter + 1;
                end else begin
                    mem_rdata = line_data(mem_addr);
                end
                mem_ack = 1'b1;
                // ack stays up until the cache drops its request
                while (mem_req) begin
                    @(posedge sys_clk);
                    #(drive_delay);
                end
                mem_ack = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: icache_top.sv
`default_nettype none

module icache_top
    import icache_pkg::*;
#(
    parameter int idx_w = 10
) (
    input  wire               sys_clk,
    input  wire               arst_n,

    // fetch stage
    input  wire               fetch_read,
    input  wire  [addr_w-1:0] fetch_addr,
    input  wire               fetch_hold,
    input  wire               flush,
    output wire  [word_w-1:0] fetch_data,
    output wire               fetch_hit,
    output wire               fetch_stall,

    // memory side, four-phase req/ack
    output wire               mem_req,
    output wire  [addr_w-1:0] mem_addr,
    output wire               mem_mmio,
    input  wire               mem_ack,
    input  wire  [line_w-1:0] mem_rdata
);

    wire              store_hit;
    wire [word_w-1:0] store_word;

    fill_if #(.idx_w(idx_w)) fill_bus ();

    // lookup uses the fetch address directly, hits answer in the same cycle
    icache_tag_store #(.idx_w(idx_w)) i_tag_store (
        .sys_clk     (sys_clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .lookup_addr (fetch_addr),
        .fill        (fill_bus.store),
        .hit         (store_hit)
    );

    icache_data_store #(.idx_w(idx_w)) i_data_store (
        .sys_clk     (sys_clk),
        .lookup_addr (fetch_addr),
        .fill        (fill_bus.store),
        .word        (store_word)
    );

    icache_ctrl #(.idx_w(idx_w)) i_ctrl (
        .sys_clk     (sys_clk),
        .arst_n      (arst_n),
        .fetch_read  (fetch_read),
        .fetch_addr  (fetch_addr),
        .fetch_hold  (fetch_hold),
        .hit         (store_hit),
        .store_word  (store_word),
        .fill        (fill_bus.ctrl),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_mmio    (mem_mmio),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .fetch_data  (fetch_data),
        .fetch_stall (fetch_stall),
        .fetch_hit   (fetch_hit)
    );

endmodule

`default_nettype wire

// File: icache_ctrl.sv
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
#(
    parameter int idx_w = 10
) (
    input  wire               sys_clk,
    input  wire               arst_n,
    input  wire               fetch_read,
    input  wire  [addr_w-1:0] fetch_addr,
    input  wire               fetch_hold,
    input  wire               hit,
    input  wire  [word_w-1:0] store_word,
    fill_if.ctrl              fill,
    output logic              mem_req,
    output logic [addr_w-1:0] mem_addr,
    output logic              mem_mmio,
    input  wire               mem_ack,
    input  wire  [line_w-1:0] mem_rdata,
    output logic [word_w-1:0] fetch_data,
    output logic              fetch_stall,
    output logic              fetch_hit
);

    localparam int tag_w = addr_w - idx_w - woff_w - boff_w;
    localparam int off_w = woff_w + boff_w;

    ctrl_state_t       state;
    logic              is_mmio;
    logic              mmio_valid;
    logic [word_w-1:0] mmio_buf;

    assign is_mmio = (fetch_addr & mmio_mask) == mmio_base;

    // four-phase sequencer toward memory
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= idle;
            mem_req    <= 1'b0;
            mem_addr   <= '0;
            mem_mmio   <= 1'b0;
            mmio_valid <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    // no new request while the previous ack is still up
                    if (fetch_read && !mem_ack) begin
                        if (is_mmio) begin
                            state    <= mmio_req;
                            mem_req  <= 1'b1;
                            mem_addr <= fetch_addr;
                            mem_mmio <= 1'b1;
                        end else if (!hit) begin
                            state    <= miss_req;
                            mem_req  <= 1'b1;
                            mem_addr <= {fetch_addr[addr_w-1:off_w], {off_w{1'b0}}};
                            mem_mmio <= 1'b0;
                        end
                    end
                end
                miss_req: begin
                    // line is written into the stores on this same edge
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= miss_release;
                    end
                end
                miss_release: begin
                    if (!mem_ack) begin
                        state <= idle;
                    end
                end
                mmio_req: begin
                    if (mem_ack) begin
                        mem_req    <= 1'b0;
                        mmio_valid <= 1'b1;
                        state      <= mmio_release;
                    end
                end
                mmio_release: begin
                    if (!mem_ack) begin
                        state <= mmio_hold;
                    end
                end
                mmio_hold: begin
                    // word is consumed in the first cycle without hold
                    if (!fetch_hold) begin
                        mmio_valid <= 1'b0;
                        state      <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // uncached word buffer
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            mmio_buf <= '0;
        end else if (state == mmio_req && mem_ack) begin
            mmio_buf <= mem_rdata[word_w-1:0];
        end
    end

    // refill straight from the memory data while ack is high
    assign fill.fill_en   = (state == miss_req) && mem_ack;
    assign fill.fill_idx  = fetch_addr[off_w +: idx_w];
    assign fill.fill_tag  = fetch_addr[addr_w-1 -: tag_w];
    assign fill.fill_line = mem_rdata;

    always_comb begin
        if (!fetch_read) begin
            fetch_stall = 1'b0;
        end else if (is_mmio) begin
            fetch_stall = (state != mmio_hold);
        end else begin
            // after a refill, wait for idle so the ack has dropped
            fetch_stall = (state != idle) || !hit;
        end
    end

    assign fetch_data = mmio_valid ? mmio_buf : store_word;
    assign fetch_hit  = fetch_read && !is_mmio && hit;

endmodule

`default_nettype wire

// File: icache_data_store.sv
`default_nettype none

module icache_data_store
    import icache_pkg::*;
#(
    parameter int idx_w = 10
) (
    input  wire              sys_clk,
    input  wire [addr_w-1:0] lookup_addr,
    fill_if.store            fill,
    output logic [word_w-1:0] word
);

    localparam int n_lines = 1 << idx_w;

    // line array, behaves like a ram with one wide write port
    logic [line_w-1:0] line_mem [n_lines];

    logic [idx_w-1:0]  rd_idx;
    logic [woff_w-1:0] rd_woff;
    logic [line_w-1:0] rd_line;

    always_ff @(posedge sys_clk) begin
        if (fill.fill_en) begin
            line_mem[fill.fill_idx] <= fill.fill_line;
        end
    end

    assign rd_idx  = lookup_addr[woff_w + boff_w +: idx_w];
    assign rd_woff = lookup_addr[boff_w +: woff_w];

    // word 0 sits in the low bits of the line
    assign rd_line = line_mem[rd_idx];
    assign word    = rd_line[rd_woff * word_w +: word_w];

endmodule

`default_nettype wire

// File: icache_tag_store.sv
`default_nettype none

module icache_tag_store
    import icache_pkg::*;
#(
    parameter int idx_w = 10
) (
    input  wire              sys_clk,
    input  wire              arst_n,
    input  wire              flush,
    input  wire [addr_w-1:0] lookup_addr,
    fill_if.store            fill,
    output logic             hit
);

    localparam int tag_w = addr_w - idx_w - woff_w - boff_w;
    localparam int n_lines = 1 << idx_w;

    logic [n_lines-1:0] valid;
    logic [tag_w-1:0]   tags [n_lines];

    logic [idx_w-1:0]   lookup_idx;
    logic [tag_w-1:0]   lookup_tag;

    // address layout is tag | index | word offset | byte offset
    assign lookup_idx = lookup_addr[woff_w + boff_w +: idx_w];
    assign lookup_tag = lookup_addr[addr_w-1 -: tag_w];

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
            for (int i = 0; i < n_lines; i++) begin
                tags[i] <= '0;
            end
        end else begin
            if (flush) begin
                valid <= '0;
            end
            // a refill in flight still lands, even in a flush cycle
            if (fill.fill_en) begin
                valid[fill.fill_idx] <= 1'b1;
                tags[fill.fill_idx] <= fill.fill_tag;
            end
        end
    end

    assign hit = valid[lookup_idx] && (tags[lookup_idx] == lookup_tag);

endmodule

`default_nettype wire

// File: fill_if.sv
`default_nettype none

interface fill_if
    import icache_pkg::*;
#(
    parameter int idx_w = 10
);

    localparam int tag_w = addr_w - idx_w - woff_w - boff_w;

    // one full line refill, written on the edge where fill_en is high
    logic              fill_en;
    logic [idx_w-1:0]  fill_idx;
    logic [tag_w-1:0]  fill_tag;
    logic [line_w-1:0] fill_line;

    modport ctrl (
        output fill_en,
        output fill_idx,
        output fill_tag,
        output fill_line
    );

    modport store (
        input fill_en,
        input fill_idx,
        input fill_tag,
        input fill_line
    );

endinterface

`default_nettype wire

// File: icache_pkg.sv
`default_nettype none

package icache_pkg;

    // fetch address and instruction word
    localparam int addr_w = 32;
    localparam int word_w = 32;

    // one cache line is eight words, also the memory read width
    localparam int line_words = 8;
    localparam int line_w = line_words * word_w;

    // offsets inside a line
    localparam int woff_w = $clog2(line_words);
    localparam int boff_w = 2;

    // uncached window is the top 256 MiB
    // an address is mmio when (addr & mmio_mask) == mmio_base
    localparam logic [addr_w-1:0] mmio_base = 32'hF000_0000;
    localparam logic [addr_w-1:0] mmio_mask = 32'hF000_0000;

    // controller states
    // miss_* refill a line, mmio_* fetch one uncached word
    // the *_release states wait for mem_ack to drop
    typedef enum logic [2:0] {
        idle         = 3'd0,
        miss_req     = 3'd1,
        miss_release = 3'd2,
        mmio_req     = 3'd3,
        mmio_release = 3'd4,
        mmio_hold    = 3'd5
    } ctrl_state_t;

endpackage

`default_nettype wire
